/* rtl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  // ------------------------------
  // Widths
  // ------------------------------

  // Data and address word
  typedef logic [31:0] word_t;
  // Architectural register index
  typedef logic [4:0] reg_addr_t;
  // ALU operation select
  typedef logic [2:0] alu_op_t;

  // First fetch address out of reset
  localparam word_t RESET_PC = 32'h0000_0000;

  // ------------------------------
  // Major opcodes
  // ------------------------------
  localparam logic [6:0] OP_RTYPE  = 7'b0110011;
  localparam logic [6:0] OP_ITYPE  = 7'b0010011;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // ALU operations
  localparam alu_op_t ALU_ADD    = 3'd0;
  localparam alu_op_t ALU_SUB    = 3'd1;
  localparam alu_op_t ALU_AND    = 3'd2;
  localparam alu_op_t ALU_OR     = 3'd3;
  localparam alu_op_t ALU_XOR    = 3'd4;
  localparam alu_op_t ALU_SLT    = 3'd5;
  // Second operand straight through, used by LUI
  localparam alu_op_t ALU_PASS_B = 3'd6;

  // ------------------------------
  // Stage registers
  // ------------------------------

  // Fetch to decode
  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t instr;
  } if_id_t;

  // Decode to execute
  typedef struct packed {
    logic      valid;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    logic      is_ebreak;
    logic      is_illegal;
    alu_op_t   alu_op;
    logic      use_imm;
    reg_addr_t rd;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     imm;
  } id_ex_t;

  // Execute to memory
  typedef struct packed {
    logic      valid;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    logic      is_ebreak;
    logic      is_illegal;
    reg_addr_t rd;
    word_t     alu_result;
    word_t     store_data;
  } ex_mem_t;

  // Writeback port into the register file
  typedef struct packed {
    logic      en;
    reg_addr_t addr;
    word_t     data;
  } rf_write_t;

endpackage

`default_nettype wire

/* rtl/rv_fetch.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_fetch
  import rv_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   stall,
  input  logic   halt_fetch,
  input  word_t  imem_rdata,
  output logic   imem_ren,
  output word_t  imem_raddr,
  output if_id_t if_id
);

  word_t pc;

  // Program counter, frozen by the interlock or after a halt
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else if (!stall && !halt_fetch) begin
      pc <= pc + 32'd4;
    end
  end

  // SRAM style fetch, word comes back in the same cycle
  assign imem_ren   = !halt_fetch;
  assign imem_raddr = pc;

  // Fetch/decode register
  // Holds under stall, only bubbles once halted
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      if_id.valid <= 1'b0;
    end else if (halt_fetch) begin
      if_id.valid <= 1'b0;
    end else if (!stall) begin
      if_id.valid <= 1'b1;
      if_id.pc    <= pc;
      if_id.instr <= imem_rdata;
    end
  end

endmodule

`default_nettype wire

/* rtl/rv_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_decode
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  if_id_t    if_id,
  input  reg_addr_t ex_rd,
  input  logic      ex_reg_write,
  input  reg_addr_t mem_rd,
  input  logic      mem_reg_write,
  input  rf_write_t rf_write,
  output logic      stall,
  output logic      halt_fetch,
  output id_ex_t    id_ex
);

  // Instruction fields
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rs1;
  reg_addr_t  rs2;
  reg_addr_t  rd;

  // Immediates
  word_t imm_i;
  word_t imm_s;
  word_t imm_u;
  word_t imm;

  // Control
  logic    reg_write;
  logic    mem_read;
  logic    mem_write;
  logic    is_ebreak;
  logic    is_illegal;
  logic    use_imm;
  logic    rs1_used;
  logic    rs2_used;
  alu_op_t alu_op;

  // Register file, x0 is not stored
  word_t regs [1:31];
  word_t rs1_data;
  word_t rs2_data;

  logic hazard;
  logic halting;
  logic halt_seen;

  assign opcode = if_id.instr[6:0];
  assign rd     = if_id.instr[11:7];
  assign funct3 = if_id.instr[14:12];
  assign rs1    = if_id.instr[19:15];
  assign rs2    = if_id.instr[24:20];
  assign funct7 = if_id.instr[31:25];

  assign imm_i = {{20{if_id.instr[31]}}, if_id.instr[31:20]};
  assign imm_s = {{20{if_id.instr[31]}}, if_id.instr[31:25], if_id.instr[11:7]};
  assign imm_u = {if_id.instr[31:12], 12'h000};

  // ------------------------------
  // Instruction decoder
  // ------------------------------
  always_comb begin
    reg_write  = 1'b0;
    mem_read   = 1'b0;
    mem_write  = 1'b0;
    is_ebreak  = 1'b0;
    is_illegal = 1'b0;
    use_imm    = 1'b0;
    rs1_used   = 1'b0;
    rs2_used   = 1'b0;
    alu_op     = ALU_ADD;
    imm        = imm_i;
    case (opcode)
      OP_RTYPE: begin
        reg_write = 1'b1;
        rs1_used  = 1'b1;
        rs2_used  = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: alu_op = ALU_ADD;
          {7'b0100000, 3'b000}: alu_op = ALU_SUB;
          {7'b0000000, 3'b111}: alu_op = ALU_AND;
          {7'b0000000, 3'b110}: alu_op = ALU_OR;
          {7'b0000000, 3'b100}: alu_op = ALU_XOR;
          {7'b0000000, 3'b010}: alu_op = ALU_SLT;
          default:              is_illegal = 1'b1;
        endcase
      end
      // Only ADDI of the immediate group
      OP_ITYPE: begin
        reg_write  = 1'b1;
        rs1_used   = 1'b1;
        use_imm    = 1'b1;
        is_illegal = (funct3 != 3'b000);
      end
      OP_LUI: begin
        reg_write = 1'b1;
        use_imm   = 1'b1;
        alu_op    = ALU_PASS_B;
        imm       = imm_u;
      end
      // Full word loads and stores only
      OP_LOAD: begin
        reg_write  = 1'b1;
        mem_read   = 1'b1;
        rs1_used   = 1'b1;
        use_imm    = 1'b1;
        is_illegal = (funct3 != 3'b010);
      end
      OP_STORE: begin
        mem_write  = 1'b1;
        rs1_used   = 1'b1;
        rs2_used   = 1'b1;
        use_imm    = 1'b1;
        imm        = imm_s;
        is_illegal = (funct3 != 3'b010);
      end
      // EBREAK is the one system word kept
      OP_SYSTEM: begin
        if ({if_id.instr[31:20], rs1, funct3, rd} == {12'h001, 13'h0000}) begin
          is_ebreak = 1'b1;
        end else begin
          is_illegal = 1'b1;
        end
      end
      default: is_illegal = 1'b1;
    endcase
    // Illegal words neither read nor write anything
    if (is_illegal) begin
      reg_write = 1'b0;
      mem_read  = 1'b0;
      mem_write = 1'b0;
      rs1_used  = 1'b0;
      rs2_used  = 1'b0;
    end
  end

  // ------------------------------
  // Register file
  // ------------------------------
  always_ff @(posedge clk) begin
    if (rf_write.en && (rf_write.addr != 5'd0)) begin
      regs[rf_write.addr] <= rf_write.data;
    end
  end

  // Read with writeback passed through in the same cycle
  function automatic word_t rf_read(input reg_addr_t a);
    if (a == 5'd0) begin
      return '0;
    end else if (rf_write.en && (rf_write.addr == a)) begin
      return rf_write.data;
    end
    return regs[a];
  endfunction

  assign rs1_data = rf_read(rs1);
  assign rs2_data = rf_read(rs2);

  // Source waits on an older writer still in execute or memory
  function automatic logic raw_dep(input logic used, input reg_addr_t r);
    return used && (r != 5'd0) &&
           ((ex_reg_write && (ex_rd == r)) || (mem_reg_write && (mem_rd == r)));
  endfunction

  assign hazard = raw_dep(rs1_used, rs1) || raw_dep(rs2_used, rs2);

  // ------------------------------
  // Interlock and halt
  // ------------------------------
  assign stall   = if_id.valid && !halt_seen && hazard;
  assign halting = if_id.valid && !halt_seen && (is_ebreak || is_illegal);

  // Sticky, squashes everything decoded after the halting word
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      halt_seen <= 1'b0;
    end else if (halting) begin
      halt_seen <= 1'b1;
    end
  end

  assign halt_fetch = halt_seen;

  // Decode/execute register, bubble on stall or after halt
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      id_ex.valid <= 1'b0;
    end else begin
      id_ex.valid      <= if_id.valid && !stall && !halt_seen;
      id_ex.reg_write  <= reg_write;
      id_ex.mem_read   <= mem_read;
      id_ex.mem_write  <= mem_write;
      id_ex.is_ebreak  <= is_ebreak;
      id_ex.is_illegal <= is_illegal;
      id_ex.alu_op     <= alu_op;
      id_ex.use_imm    <= use_imm;
      id_ex.rd         <= rd;
      id_ex.rs1_data   <= rs1_data;
      id_ex.rs2_data   <= rs2_data;
      id_ex.imm        <= imm;
    end
  end

endmodule

`default_nettype wire

/* rtl/rv_execute.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_execute
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  id_ex_t    id_ex,
  output ex_mem_t   ex_mem,
  output reg_addr_t ex_rd,
  output logic      ex_reg_write
);

  word_t op_b;
  word_t alu_result;

  // Immediate or register for the second operand
  assign op_b = id_ex.use_imm ? id_ex.imm : id_ex.rs2_data;

  // ------------------------------
  // ALU
  // ------------------------------
  always_comb begin
    case (id_ex.alu_op)
      ALU_ADD:    alu_result = id_ex.rs1_data + op_b;
      ALU_SUB:    alu_result = id_ex.rs1_data - op_b;
      ALU_AND:    alu_result = id_ex.rs1_data & op_b;
      ALU_OR:     alu_result = id_ex.rs1_data | op_b;
      ALU_XOR:    alu_result = id_ex.rs1_data ^ op_b;
      // Signed compare, result is 0 or 1
      ALU_SLT:    alu_result = {31'd0, $signed(id_ex.rs1_data) < $signed(op_b)};
      ALU_PASS_B: alu_result = op_b;
      default:    alu_result = '0;
    endcase
  end

  // Writer seen by the decode interlock
  assign ex_rd        = id_ex.rd;
  assign ex_reg_write = id_ex.valid && id_ex.reg_write;

  // Execute/memory register, never stalls
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_mem.valid <= 1'b0;
    end else begin
      ex_mem.valid      <= id_ex.valid;
      ex_mem.reg_write  <= id_ex.reg_write;
      ex_mem.mem_read   <= id_ex.mem_read;
      ex_mem.mem_write  <= id_ex.mem_write;
      ex_mem.is_ebreak  <= id_ex.is_ebreak;
      ex_mem.is_illegal <= id_ex.is_illegal;
      ex_mem.rd         <= id_ex.rd;
      ex_mem.alu_result <= alu_result;
      ex_mem.store_data <= id_ex.rs2_data;
    end
  end

endmodule

`default_nettype wire

/* rtl/rv_memory.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_memory
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  ex_mem_t   ex_mem,
  input  word_t     dmem_rdata,
  output logic      dmem_ren,
  output logic      dmem_we,
  output word_t     dmem_raddr,
  output word_t     dmem_waddr,
  output word_t     dmem_wdata,
  output reg_addr_t mem_rd,
  output logic      mem_reg_write,
  output rf_write_t rf_write,
  output logic      ebreak,
  output logic      trap
);

  word_t result;

  // ------------------------------
  // Data memory access
  // ------------------------------

  // Zero latency SRAM, full words only
  assign dmem_ren   = ex_mem.valid && ex_mem.mem_read;
  assign dmem_we    = ex_mem.valid && ex_mem.mem_write;
  assign dmem_raddr = ex_mem.alu_result;
  assign dmem_waddr = ex_mem.alu_result;
  assign dmem_wdata = ex_mem.store_data;

  // Writer seen by the decode interlock
  assign mem_rd        = ex_mem.rd;
  assign mem_reg_write = ex_mem.valid && ex_mem.reg_write;

  // Load data or ALU result
  assign result = ex_mem.mem_read ? dmem_rdata : ex_mem.alu_result;

  // Memory/writeback register, drives the register file directly
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rf_write.en <= 1'b0;
    end else begin
      rf_write.en   <= mem_reg_write;
      rf_write.addr <= ex_mem.rd;
      rf_write.data <= result;
    end
  end

  // Halt flags set as the halting word enters writeback
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ebreak <= 1'b0;
      trap   <= 1'b0;
    end else begin
      if (ex_mem.valid && ex_mem.is_ebreak) begin
        ebreak <= 1'b1;
      end
      if (ex_mem.valid && ex_mem.is_illegal) begin
        trap <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/rv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core
  import rv_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,

  // Instruction memory, read only
  output logic  imem_ren,
  output word_t imem_raddr,
  input  word_t imem_rdata,

  // Data memory read side
  output logic  dmem_ren,
  output word_t dmem_raddr,
  input  word_t dmem_rdata,

  // Data memory write side
  output logic  dmem_we,
  output word_t dmem_waddr,
  output word_t dmem_wdata,

  // Sticky halt status
  output logic  ebreak,
  output logic  trap
);

  // ------------------------------
  // Stage to stage
  // ------------------------------
  if_id_t    if_id;
  id_ex_t    id_ex;
  ex_mem_t   ex_mem;
  rf_write_t rf_write;

  // Decode control to fetch
  logic stall;
  logic halt_fetch;

  // Writers in flight, for the interlock
  reg_addr_t ex_rd;
  logic      ex_reg_write;
  reg_addr_t mem_rd;
  logic      mem_reg_write;

  rv_fetch u_fetch (
    .clk        (clk),
    .rst_n      (rst_n),
    .stall      (stall),
    .halt_fetch (halt_fetch),
    .imem_rdata (imem_rdata),
    .imem_ren   (imem_ren),
    .imem_raddr (imem_raddr),
    .if_id      (if_id)
  );

  rv_decode u_decode (
    .clk           (clk),
    .rst_n         (rst_n),
    .if_id         (if_id),
    .ex_rd         (ex_rd),
    .ex_reg_write  (ex_reg_write),
    .mem_rd        (mem_rd),
    .mem_reg_write (mem_reg_write),
    .rf_write      (rf_write),
    .stall         (stall),
    .halt_fetch    (halt_fetch),
    .id_ex         (id_ex)
  );

  rv_execute u_execute (
    .clk          (clk),
    .rst_n        (rst_n),
    .id_ex        (id_ex),
    .ex_mem       (ex_mem),
    .ex_rd        (ex_rd),
    .ex_reg_write (ex_reg_write)
  );

  // Memory stage also holds writeback and the halt flags
  rv_memory u_memory (
    .clk           (clk),
    .rst_n         (rst_n),
    .ex_mem        (ex_mem),
    .dmem_rdata    (dmem_rdata),
    .dmem_ren      (dmem_ren),
    .dmem_we       (dmem_we),
    .dmem_raddr    (dmem_raddr),
    .dmem_waddr    (dmem_waddr),
    .dmem_wdata    (dmem_wdata),
    .mem_rd        (mem_rd),
    .mem_reg_write (mem_reg_write),
    .rf_write      (rf_write),
    .ebreak        (ebreak),
    .trap          (trap)
  );

endmodule

`default_nettype wire

/* sim/rv_core_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core_properties (
  input logic clk,
  input logic rst_n,
  input logic dmem_we,
  input logic dmem_ren,
  input logic ebreak,
  input logic trap
);

  // A word is either loaded or stored, never both
  a_we_ren_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(dmem_we && dmem_ren)) else $error("dmem_we and dmem_ren high in the same cycle");

  // Halt flags hold until reset
  a_ebreak_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    ebreak |=> ebreak) else $error("ebreak dropped without reset");
  a_trap_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    trap |=> trap) else $error("trap dropped without reset");

  // Nothing younger than the halting word reaches memory
  a_no_store_halted: assert property (@(posedge clk) disable iff (!rst_n)
    (ebreak || trap) |=> !dmem_we) else $error("store seen after the core halted");

endmodule

bind rv_core rv_core_properties props0 (
  .clk      (clk),
  .rst_n    (rst_n),
  .dmem_we  (dmem_we),
  .dmem_ren (dmem_ren),
  .ebreak   (ebreak),
  .trap     (trap)
);

`default_nettype wire

/* sim/tb_rv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core
  import rv_pkg::*;
();

  // ------------------------------
  // Sizes and fixed words
  // ------------------------------
  localparam int    NUM_PROGS    = 4;
  localparam int    IMEM_WORDS   = 64;
  localparam int    DMEM_WORDS   = 256;
  localparam int    MAX_STORES   = 8;
  localparam int    DRAIN_CYCLES = 8;
  localparam word_t EBREAK_WORD  = 32'h0010_0073;
  // Opcode 7'h7f is not RV32I
  localparam word_t ILLEGAL_WORD = 32'hffff_ffff;

  logic  clk = 1'b0;
  logic  rst_n;
  logic  imem_ren;
  word_t imem_raddr;
  word_t imem_rdata;
  logic  dmem_ren;
  word_t dmem_raddr;
  word_t dmem_rdata;
  logic  dmem_we;
  word_t dmem_waddr;
  word_t dmem_wdata;
  logic  ebreak;
  logic  trap;

  // Program table with the expected store log and halt kind
  word_t prog_instr [NUM_PROGS][IMEM_WORDS];
  int    prog_len   [NUM_PROGS];
  word_t exp_addr   [NUM_PROGS][MAX_STORES];
  word_t exp_data   [NUM_PROGS][MAX_STORES];
  int    exp_stores [NUM_PROGS];
  logic  exp_trap   [NUM_PROGS];

  // Memory models and store log
  word_t imem [IMEM_WORDS];
  word_t dmem [DMEM_WORDS];
  word_t log_addr [$];
  word_t log_data [$];

  int error_count = 0;
  int cycle_count = 0;
  int cycle_limit = 1000;

  rv_core dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_ren   (imem_ren),
    .imem_raddr (imem_raddr),
    .imem_rdata (imem_rdata),
    .dmem_ren   (dmem_ren),
    .dmem_raddr (dmem_raddr),
    .dmem_rdata (dmem_rdata),
    .dmem_we    (dmem_we),
    .dmem_waddr (dmem_waddr),
    .dmem_wdata (dmem_wdata),
    .ebreak     (ebreak),
    .trap       (trap)
  );

  always #2 clk = ~clk;

  // Zero latency reads, word addressed
  assign imem_rdata = imem[imem_raddr[7:2]];
  // Load data only while the read strobe is up
  assign dmem_rdata = dmem_ren ? dmem[dmem_raddr[9:2]] : '0;

  // Stores land on the falling edge, where the strobe is stable
  always @(negedge clk) begin
    if (rst_n && (dmem_we === 1'b1)) begin
      dmem[dmem_waddr[9:2]] = dmem_wdata;
      log_addr.push_back(dmem_waddr);
      log_data.push_back(dmem_wdata);
    end
  end

  // Run limit over all programs
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: the core did not halt within %0d cycles", cycle_limit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // ------------------------------
  // Instruction encoders
  // ------------------------------
  function automatic word_t rtype_word(input int f7, input int f3, input int rd,
                                       input int rs1, input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic word_t addi_word(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
  endfunction

  function automatic word_t lw_word(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
  endfunction

  // S format splits the offset around rs2 and rs1
  function automatic word_t sw_word(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t lui_word(input int rd, input int upper);
    return {upper[19:0], rd[4:0], 7'b0110111};
  endfunction

  task automatic push_instr(input int p, input word_t w);
    prog_instr[p][prog_len[p]] = w;
    prog_len[p] += 1;
  endtask

  task automatic expect_store(input int p, input word_t a, input word_t d);
    exp_addr[p][exp_stores[p]] = a;
    exp_data[p][exp_stores[p]] = d;
    exp_stores[p] += 1;
  endtask

  // ------------------------------
  // Program table
  // ------------------------------
  task automatic build_programs();
    for (int p = 0; p < NUM_PROGS; p++) begin
      prog_len[p]   = 0;
      exp_stores[p] = 0;
    end
    // ALU group, x1 = 5 and x2 = -3, dependent pairs stall in decode
    push_instr(0, addi_word(1, 0, 5));
    push_instr(0, addi_word(2, 0, -3));
    push_instr(0, rtype_word(7'h00, 0, 3, 1, 2));
    push_instr(0, rtype_word(7'h20, 0, 4, 1, 2));
    push_instr(0, rtype_word(7'h00, 7, 5, 1, 2));
    push_instr(0, rtype_word(7'h00, 6, 6, 1, 2));
    push_instr(0, rtype_word(7'h00, 4, 7, 1, 2));
    push_instr(0, rtype_word(7'h00, 2, 8, 2, 1));
    push_instr(0, rtype_word(7'h00, 2, 10, 1, 2));
    push_instr(0, lui_word(9, 32'h12345));
    for (int r = 3; r <= 10; r++) begin
      push_instr(0, sw_word(r, 0, 32'h100 + 4 * (r - 3)));
    end
    push_instr(0, EBREAK_WORD);
    expect_store(0, 32'h100, 32'h0000_0002);
    expect_store(0, 32'h104, 32'h0000_0008);
    expect_store(0, 32'h108, 32'h0000_0005);
    expect_store(0, 32'h10c, 32'hffff_fffd);
    expect_store(0, 32'h110, 32'hffff_fff8);
    expect_store(0, 32'h114, 32'h0000_0001);
    expect_store(0, 32'h118, 32'h1234_5000);
    expect_store(0, 32'h11c, 32'h0000_0000);
    exp_trap[0] = 1'b0;
    // Load use, every consumer directly behind its load
    push_instr(1, lw_word(1, 0, 32'h40));
    push_instr(1, rtype_word(7'h00, 0, 2, 1, 1));
    push_instr(1, sw_word(2, 0, 32'h80));
    push_instr(1, lw_word(3, 0, 32'h44));
    push_instr(1, sw_word(3, 0, 32'h84));
    push_instr(1, addi_word(4, 0, 32'h20));
    push_instr(1, lw_word(5, 4, 32'h30));
    push_instr(1, sw_word(5, 4, 4));
    push_instr(1, EBREAK_WORD);
    expect_store(1, 32'h80, 32'hb4b4_0080);
    expect_store(1, 32'h84, 32'h5a5a_0044);
    expect_store(1, 32'h24, 32'h5a5a_0050);
    exp_trap[1] = 1'b0;
    // Writes to x0 from ALU and load paths are dropped
    push_instr(2, addi_word(0, 0, 32'h7ff));
    push_instr(2, addi_word(1, 0, 32'h123));
    push_instr(2, rtype_word(7'h00, 0, 0, 1, 1));
    push_instr(2, sw_word(0, 0, 32'h200));
    push_instr(2, lw_word(0, 0, 32'h40));
    push_instr(2, rtype_word(7'h00, 0, 2, 0, 1));
    push_instr(2, sw_word(0, 0, 32'h204));
    push_instr(2, sw_word(2, 0, 32'h208));
    push_instr(2, EBREAK_WORD);
    expect_store(2, 32'h200, 32'h0000_0000);
    expect_store(2, 32'h204, 32'h0000_0000);
    expect_store(2, 32'h208, 32'h0000_0123);
    exp_trap[2] = 1'b0;
    // Illegal word traps, older stores still retire
    push_instr(3, addi_word(1, 0, 32'h55));
    push_instr(3, sw_word(1, 0, 32'h300));
    push_instr(3, lui_word(2, 32'habcde));
    push_instr(3, sw_word(2, 0, 32'h304));
    push_instr(3, ILLEGAL_WORD);
    expect_store(3, 32'h300, 32'h0000_0055);
    expect_store(3, 32'h304, 32'habcd_e000);
    exp_trap[3] = 1'b1;
  endtask

  task automatic check_value(input string what, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      error_count++;
      $display("FAIL %0t %s: got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // ------------------------------
  // One program: reset, load, run to halt, compare
  // ------------------------------
  task automatic run_program(input int p);
    logic halted;
    @(negedge clk);
    rst_n = 1'b0;
    // Unused words are random and must never retire
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = (i < prog_len[p]) ? prog_instr[p][i] : $urandom;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] = word_t'(i * 4) ^ 32'h5a5a_0000;
    end
    repeat (3) @(negedge clk);
    log_addr.delete();
    log_data.delete();
    // State right out of reset
    check_value($sformatf("prog%0d dmem_we", p), {31'd0, dmem_we}, 32'd0);
    check_value($sformatf("prog%0d dmem_ren", p), {31'd0, dmem_ren}, 32'd0);
    check_value($sformatf("prog%0d imem_ren", p), {31'd0, imem_ren}, 32'd1);
    check_value($sformatf("prog%0d ebreak", p), {31'd0, ebreak}, 32'd0);
    check_value($sformatf("prog%0d trap", p), {31'd0, trap}, 32'd0);
    check_value($sformatf("prog%0d imem_raddr", p), imem_raddr, 32'd0);
    rst_n = 1'b1;
    halted = 1'b0;
    while (!halted) begin
      @(negedge clk);
      halted = ebreak || trap;
    end
    // Let anything stray show up in the log
    repeat (DRAIN_CYCLES) @(negedge clk);
    @(posedge clk);
    check_value($sformatf("prog%0d store count", p), log_addr.size(), exp_stores[p]);
    for (int i = 0; (i < exp_stores[p]) && (i < log_addr.size()); i++) begin
      check_value($sformatf("prog%0d dmem_waddr #%0d", p, i), log_addr[i], exp_addr[p][i]);
      check_value($sformatf("prog%0d dmem_wdata #%0d", p, i), log_data[i], exp_data[p][i]);
    end
    check_value($sformatf("prog%0d ebreak", p), {31'd0, ebreak}, {31'd0, !exp_trap[p]});
    check_value($sformatf("prog%0d trap", p), {31'd0, trap}, {31'd0, exp_trap[p]});
    // Fetch stays off once halted
    check_value($sformatf("prog%0d imem_ren halted", p), {31'd0, imem_ren}, 32'd0);
  endtask

  initial begin
    int total_instr;
    void'($urandom(32'h996d6be2));
    rst_n = 1'b0;
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = '0;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] = '0;
    end
    build_programs();
    total_instr = 0;
    for (int p = 0; p < NUM_PROGS; p++) begin
      total_instr += prog_len[p];
    end
    cycle_limit = 4 * total_instr + 20 * NUM_PROGS;
    for (int p = 0; p < NUM_PROGS; p++) begin
      run_program(p);
    end
    $display("Programs run: %0d, errors: %0d", NUM_PROGS, error_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
rtl/rv_pkg.sv
rtl/rv_fetch.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_memory.sv
rtl/rv_core.sv
sim/rv_core_properties.sv
sim/tb_rv_core.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_rv_core \
  -f project.f

out=$(./obj_dir/Vtb_rv_core)
echo "$out"

if echo "$out" | grep -qx "SIMULATION PASSED"; then
  exit 0
fi
echo "run_sim.sh: pass line not found in simulation output"
exit 1
